//--- src.f
hw/sifh_pkg.sv
hw/hist_rd_if.sv
hw/hist_accum.sv
hw/hist_merge.sv
hw/sifh_top.sv
bench/clk_gen.sv
bench/tb_sifh.sv

//--- Makefile
# Verilator build for the frame histogram project

VERILATOR ?= verilator
FILELIST ?= src.f
TOP ?= tb_sifh
RTL_TOP ?= sifh_top
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Simulation finished: PASS
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "sim passed" || (echo "sim failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_sifh.sv
`timescale 1ns/100ps

module tb_sifh;

    import sifh_pkg::*;

    // event patterns per lane
    localparam int PAT_ONE = 0;
    localparam int PAT_SWEEP = 1;
    localparam int PAT_RAND = 2;

    localparam int SEED = 93573;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_ROWS = 7;
    localparam int CNT_MAX = (1 << CNT_W) - 1;

    // up to 3 idle cycles before each event on a stalled lane
    localparam int STALL_MAX = 4;
    // slack for the worst out_ready probability in the table
    localparam int BP_FACTOR = 10;
    localparam int TIMEOUT = NUM_ROWS * (2 * FRAME_EVENTS * STALL_MAX
                           + 3 * NUM_BINS * BP_FACTOR) + RESET_CYCLES + NUM_BINS;

    // one frame per row
    typedef struct {
        int kind_a;
        int bin_a;
        bit stall_a;
        int kind_b;
        int bin_b;
        bit stall_b;
        int bp_pct;
    } row_t;

    logic clk;
    logic res;
    logic ev_a_valid;
    logic ev_a_ready;
    bin_t ev_a_bin;
    logic ev_b_valid;
    logic ev_b_ready;
    bin_t ev_b_bin;
    logic out_valid;
    logic out_ready;
    bin_t out_bin;
    sum_t out_count;
    logic out_last;
    bin_t peak_bin;
    sum_t peak_count;

    row_t rows [NUM_ROWS];

    // reference histograms indexed by lane first
    int hist [2][NUM_BINS];
    int accepted [2];

    int count_errs = 0;
    int peak_errs = 0;
    int beat_errs = 0;
    int ready_errs = 0;
    int order_errs = 0;
    int hang_errs = 0;
    int cycles = 0;

    clk_gen clk_gen_i (
        .clk(clk)
    );

    sifh_top dut_i (
        .clk(clk),
        .res(res),
        .ev_a_valid(ev_a_valid),
        .ev_a_ready(ev_a_ready),
        .ev_a_bin(ev_a_bin),
        .ev_b_valid(ev_b_valid),
        .ev_b_ready(ev_b_ready),
        .ev_b_bin(ev_b_bin),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_bin(out_bin),
        .out_count(out_count),
        .out_last(out_last),
        .peak_bin(peak_bin),
        .peak_count(peak_count)
    );

    // pattern, bin and stall for lane A and for lane B plus the out_ready stall percent
    task automatic load_table();
        // same bin back to back in both lanes gives 40 in bin 5
        rows[0] = '{PAT_ONE, 5, 1'b0, PAT_ONE, 5, 1'b0, 0};
        // equal sweeps make bins 0..3 tie at 4
        rows[1] = '{PAT_SWEEP, 0, 1'b0, PAT_SWEEP, 0, 1'b0, 30};
        // offset sweeps make eight bins tie at 3 with the peak at bin 2
        rows[2] = '{PAT_SWEEP, 6, 1'b0, PAT_SWEEP, 2, 1'b0, 0};
        rows[3] = '{PAT_RAND, 0, 1'b0, PAT_RAND, 0, 1'b0, 50};
        // lane A paced slowly
        rows[4] = '{PAT_ONE, 15, 1'b1, PAT_RAND, 0, 1'b0, 20};
        // lane B paced slowly under heavy back-pressure
        rows[5] = '{PAT_RAND, 0, 1'b0, PAT_SWEEP, 9, 1'b1, 60};
        // two separate peaks of 20 where the lower bin wins
        rows[6] = '{PAT_ONE, 12, 1'b0, PAT_ONE, 3, 1'b0, 10};
    endtask

    task automatic clear_model();
        int i;
        for (i = 0; i < NUM_BINS; i++) begin
            hist[0][i] = 0;
            hist[1][i] = 0;
        end
        accepted[0] = 0;
        accepted[1] = 0;
    endtask

    // summed count of one bin
    function automatic sum_t expected_sum(input bin_t b);
        return sum_t'(hist[0][b] + hist[1][b]);
    endfunction

    // lowest bin holding the greatest sum
    task automatic find_peak(output bin_t pb, output sum_t pc);
        int i;
        sum_t s;
        pb = '0;
        pc = expected_sum('0);
        for (i = 1; i < NUM_BINS; i++) begin
            s = expected_sum(bin_t'(i));
            if (s > pc) begin
                pc = s;
                pb = bin_t'(i);
            end
        end
    endtask

    task automatic check_count(input bin_t b, input sum_t exp_cnt, input sum_t got_cnt);
        if (got_cnt !== exp_cnt) begin
            $display("ERR %0t: bin %0d count expected %0d got %0d",
                     $time, b, exp_cnt, got_cnt);
            count_errs++;
        end
    endtask

    task automatic check_peak(input bin_t exp_bin, input sum_t exp_cnt,
                              input bin_t got_bin, input sum_t got_cnt);
        if ((got_bin !== exp_bin) || (got_cnt !== exp_cnt)) begin
            $display("ERR %0t: peak expected bin %0d count %0d got bin %0d count %0d",
                     $time, exp_bin, exp_cnt, got_bin, got_cnt);
            peak_errs++;
        end
    endtask

    task automatic verify_beat(input bin_t exp_bin, input logic exp_last,
                               input bin_t got_bin, input logic got_last);
        if ((got_bin !== exp_bin) || (got_last !== exp_last)) begin
            $display("ERR %0t: beat expected bin %0d last %0b got bin %0d last %0b",
                     $time, exp_bin, exp_last, got_bin, got_last);
            beat_errs++;
        end
    endtask

    task automatic check_ready(input int lane, input logic exp_rdy, input logic got_rdy);
        if (got_rdy !== exp_rdy) begin
            $display("ERR %0t: lane %0d ready expected %0b got %0b",
                     $time, lane, exp_rdy, got_rdy);
            ready_errs++;
        end
    endtask

    task automatic set_lane(input int lane, input logic v, input bin_t b);
        if (lane == 0) begin
            ev_a_valid = v;
            ev_a_bin = b;
        end else begin
            ev_b_valid = v;
            ev_b_bin = b;
        end
    endtask

    // ready is registered and stable at the falling edge
    function automatic logic lane_ready(input int lane);
        return (lane == 0) ? ev_a_ready : ev_b_ready;
    endfunction

    // one frame of events on one lane entered on a falling edge
    task automatic drive_lane(input int lane, input int kind, input int param,
                              input bit stall);
        int i;
        int gaps;
        bin_t b;
        for (i = 0; i < FRAME_EVENTS; i++) begin
            case (kind)
                PAT_ONE: b = bin_t'(param);
                PAT_SWEEP: b = bin_t'((param + i) % NUM_BINS);
                default: b = bin_t'($urandom_range(NUM_BINS - 1));
            endcase
            if (stall) begin
                gaps = int'($urandom_range(STALL_MAX - 1));
                repeat (gaps) begin
                    set_lane(lane, 1'b0, '0);
                    @(negedge clk);
                end
            end
            set_lane(lane, 1'b1, b);
            // hold until the lane takes it
            while (!lane_ready(lane)) begin
                @(negedge clk);
            end
            // transfer lands on the coming rising edge
            if (hist[lane][b] < CNT_MAX) begin
                hist[lane][b]++;
            end
            accepted[lane]++;
            @(negedge clk);
        end
        set_lane(lane, 1'b0, '0);
        // frame closed so the lane stops taking events in the next cycle
        check_ready(lane, 1'b0, lane_ready(lane));
    endtask

    // takes one full readout under random back-pressure
    task automatic collect_frame(input int bp_pct);
        int beat;
        logic seen;
        bin_t exp_pb;
        sum_t exp_pc;
        beat = 0;
        seen = 1'b0;
        while (beat < NUM_BINS) begin
            @(negedge clk);
            out_ready = (int'($urandom_range(99)) >= bp_pct);
            if (out_valid) begin
                // readout only after both lanes closed
                if (!seen) begin
                    seen = 1'b1;
                    if ((accepted[0] != FRAME_EVENTS) || (accepted[1] != FRAME_EVENTS)) begin
                        $display("out_valid rose at %0t before both lanes finished the frame",
                                 $time);
                        order_errs++;
                    end
                end
                if (out_ready) begin
                    verify_beat(bin_t'(beat), (beat == NUM_BINS - 1), out_bin, out_last);
                    check_count(bin_t'(beat), expected_sum(bin_t'(beat)), out_count);
                    if (beat == NUM_BINS - 1) begin
                        find_peak(exp_pb, exp_pc);
                        check_peak(exp_pb, exp_pc, peak_bin, peak_count);
                    end
                    beat++;
                end
            end
        end
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    task automatic finish_run();
        int total;
        total = count_errs + peak_errs + beat_errs + ready_errs + order_errs + hang_errs;
        $display("errors: count %0d peak %0d beat %0d ready %0d order %0d hang %0d",
                 count_errs, peak_errs, beat_errs, ready_errs, order_errs, hang_errs);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles == TIMEOUT) begin
            $display("run hung: frames not finished after %0d cycles", TIMEOUT);
            hang_errs++;
            finish_run();
        end
    end

    initial begin
        int r;
        void'($urandom(SEED));
        res = 1'b0;
        ev_a_valid = 1'b0;
        ev_a_bin = '0;
        ev_b_valid = 1'b0;
        ev_b_bin = '0;
        out_ready = 1'b0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        res = 1'b1;
        // lanes sit in clear first and the drivers wait on ready
        for (r = 0; r < NUM_ROWS; r++) begin
            clear_model();
            fork
                drive_lane(0, rows[r].kind_a, rows[r].bin_a, rows[r].stall_a);
                drive_lane(1, rows[r].kind_b, rows[r].bin_b, rows[r].stall_b);
                collect_frame(rows[r].bp_pct);
            join
        end
        finish_run();
    end

endmodule

//--- bench/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
    output logic clk
);

    // 4 ns period, 50 percent duty
    localparam real HALF_PERIOD = 2.0;

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- hw/sifh_top.sv
`timescale 1ns/100ps

module sifh_top (
    input logic clk,
    input logic res,

    // lane A events
    input logic ev_a_valid,
    output logic ev_a_ready,
    input sifh_pkg::bin_t ev_a_bin,

    // lane B events
    input logic ev_b_valid,
    output logic ev_b_ready,
    input sifh_pkg::bin_t ev_b_bin,

    // merged histogram stream
    output logic out_valid,
    input logic out_ready,
    output sifh_pkg::bin_t out_bin,
    output sifh_pkg::sum_t out_count,
    output logic out_last,
    output sifh_pkg::bin_t peak_bin,
    output sifh_pkg::sum_t peak_count
);

    // lane to merge links
    hist_rd_if rd_a_if ();
    hist_rd_if rd_b_if ();

    // lane A histogram
    hist_accum acc_a_i (
        .clk(clk),
        .res(res),
        .ev_valid(ev_a_valid),
        .ev_ready(ev_a_ready),
        .ev_bin(ev_a_bin),
        .rd(rd_a_if)
    );

    // lane B histogram
    hist_accum acc_b_i (
        .clk(clk),
        .res(res),
        .ev_valid(ev_b_valid),
        .ev_ready(ev_b_ready),
        .ev_bin(ev_b_bin),
        .rd(rd_b_if)
    );

    // sum, peak and release
    hist_merge merge_i (
        .clk(clk),
        .res(res),
        .lane_a(rd_a_if),
        .lane_b(rd_b_if),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_bin(out_bin),
        .out_count(out_count),
        .out_last(out_last),
        .peak_bin(peak_bin),
        .peak_count(peak_count)
    );

endmodule

//--- hw/hist_merge.sv
`timescale 1ns/100ps

module hist_merge (
    input logic clk,
    input logic res,
    hist_rd_if.merge lane_a,
    hist_rd_if.merge lane_b,
    output logic out_valid,
    input logic out_ready,
    output sifh_pkg::bin_t out_bin,
    output sifh_pkg::sum_t out_count,
    output logic out_last,
    output sifh_pkg::bin_t peak_bin,
    output sifh_pkg::sum_t peak_count
);

    import sifh_pkg::*;

    mrg_state_t state;

    logic both_done;
    logic beat_done;
    logic rd_req;
    bin_t rd_bin;
    sum_t bin_sum;

    // start only when both lanes have closed
    assign both_done = lane_a.frame_done && lane_b.frame_done;

    // output beat taken by the sink
    assign beat_done = (state == MRG_SEND) && out_ready;

    // first read from idle
    // later reads in the cycle the previous beat goes out
    assign rd_req = ((state == MRG_IDLE) && both_done)
                 || (beat_done && !out_last);

    // next bin while sending, current bin otherwise
    assign rd_bin = (state == MRG_SEND) ? out_bin + 1'b1 : out_bin;

    // both lanes are read in lockstep
    assign lane_a.rd_en = rd_req;
    assign lane_b.rd_en = rd_req;
    assign lane_a.rd_addr = rd_bin;
    assign lane_b.rd_addr = rd_bin;

    // release pulse goes to both lanes together
    assign lane_a.release_frame = (state == MRG_RELEASE);
    assign lane_b.release_frame = (state == MRG_RELEASE);

    // widen before adding, no overflow at 9 bits
    assign bin_sum = sum_t'(lane_a.rd_data) + sum_t'(lane_b.rd_data);

    // readout FSM and beat control
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= MRG_IDLE;
            out_bin <= '0;
            out_valid <= 1'b0;
            out_last <= 1'b0;
        end else begin
            case (state)
                MRG_IDLE: begin
                    if (both_done) begin
                        state <= MRG_READ;
                    end
                end
                MRG_READ: begin
                    // lane words arrive here
                    out_valid <= 1'b1;
                    out_last <= (out_bin == bin_t'(NUM_BINS - 1));
                    state <= MRG_SEND;
                end
                MRG_SEND: begin
                    // hold the beat until taken
                    if (out_ready) begin
                        out_valid <= 1'b0;
                        out_last <= 1'b0;
                        if (out_last) begin
                            out_bin <= '0;
                            state <= MRG_RELEASE;
                        end else begin
                            out_bin <= out_bin + 1'b1;
                            state <= MRG_READ;
                        end
                    end
                end
                MRG_RELEASE: begin
                    state <= MRG_IDLE;
                end
                default: begin
                    state <= MRG_IDLE;
                end
            endcase
        end
    end

    // sum register and running peak
    always_ff @(posedge clk) begin
        if (state == MRG_READ) begin
            out_count <= bin_sum;
            // bin 0 seeds the peak, later bins must beat it
            // so a tie keeps the lower bin
            if ((out_bin == '0) || (bin_sum > peak_count)) begin
                peak_count <= bin_sum;
                peak_bin <= out_bin;
            end
        end
    end

    // beat held under back-pressure
    a_out_stable: assert property (
        @(posedge clk) disable iff (!res)
        (out_valid && !out_ready) |=> ($stable(out_bin) && $stable(out_count))
    );

    // no lane read before both frames have closed
    a_rd_when_done: assert property (
        @(posedge clk) disable iff (!res)
        rd_req |-> (lane_a.frame_done && lane_b.frame_done)
    );

endmodule

//--- hw/hist_accum.sv
`timescale 1ns/100ps

module hist_accum (
    input logic clk,
    input logic res,
    input logic ev_valid,
    output logic ev_ready,
    input sifh_pkg::bin_t ev_bin,
    hist_rd_if.lane rd
);

    import sifh_pkg::*;

    // events seen in the current frame
    typedef logic [$clog2(FRAME_EVENTS)-1:0] evt_cnt_t;

    // histogram memory with async read and one write per cycle
    count_t mem [NUM_BINS];

    acc_state_t state;
    evt_cnt_t ev_cnt;
    bin_t clr_addr;

    // write-back stage that also feeds the bypass
    logic wr_vld;
    bin_t wr_bin;
    count_t wr_cnt;

    logic accept;
    logic rd_hit;
    count_t cur_cnt;
    count_t inc_cnt;

    // events only flow while counting
    assign ev_ready = (state == ACC_RUN);
    assign accept = ev_valid && ev_ready;

    // done once the last increment is in memory
    assign rd.frame_done = (state == ACC_DONE) && !wr_vld;

    // reads only honoured on a closed frame
    assign rd_hit = rd.rd_en && rd.frame_done;

    // same bin still in flight so take the pending value
    assign cur_cnt = (wr_vld && (wr_bin == ev_bin)) ? wr_cnt : mem[ev_bin];

    // stick at full scale
    assign inc_cnt = (cur_cnt == '1) ? cur_cnt : cur_cnt + 1'b1;

    // frame control
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= ACC_CLEAR;
            ev_cnt <= '0;
            clr_addr <= '0;
            wr_vld <= 1'b0;
        end else begin
            wr_vld <= accept;
            case (state)
                ACC_CLEAR: begin
                    // one word per cycle and wrap back to bin 0
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_addr == bin_t'(NUM_BINS - 1)) begin
                        state <= ACC_RUN;
                    end
                end
                ACC_RUN: begin
                    if (accept) begin
                        if (ev_cnt == evt_cnt_t'(FRAME_EVENTS - 1)) begin
                            ev_cnt <= '0;
                            state <= ACC_DONE;
                        end else begin
                            ev_cnt <= ev_cnt + 1'b1;
                        end
                    end
                end
                ACC_DONE: begin
                    // merge has drained and zeroed the memory
                    if (rd.release_frame) begin
                        state <= ACC_RUN;
                    end
                end
                default: begin
                    state <= ACC_CLEAR;
                end
            endcase
        end
    end

    // capture the incremented count for the write-back cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_bin <= ev_bin;
            wr_cnt <= inc_cnt;
        end
    end

    // memory writes
    // clear, write-back and clear-on-read never overlap in time
    always_ff @(posedge clk) begin
        if (state == ACC_CLEAR) begin
            mem[clr_addr] <= '0;
        end else if (wr_vld) begin
            mem[wr_bin] <= wr_cnt;
        end else if (rd_hit) begin
            mem[rd.rd_addr] <= '0;
        end
    end

    // read port returns the word and zeroes it on the same edge
    always_ff @(posedge clk) begin
        if (rd_hit) begin
            rd.rd_data <= mem[rd.rd_addr];
        end
    end

    // event intake never overlaps a readout or a release of this lane
    a_accept_run: assert property (
        @(posedge clk) disable iff (!res)
        accept |-> !rd.rd_en && !rd.release_frame
    );

    // merge only releases a lane that has finished
    a_release_done: assert property (
        @(posedge clk) disable iff (!res)
        rd.release_frame |-> rd.frame_done
    );

endmodule

//--- hw/hist_rd_if.sv
`timescale 1ns/100ps

interface hist_rd_if;

    // lane has closed its frame, all writes landed
    logic frame_done;

    // one-cycle pulse from merge, lane resumes counting
    logic release_frame;

    // read request, answered one cycle later
    logic rd_en;
    sifh_pkg::bin_t rd_addr;

    // registered read word
    // the addressed word is zeroed on the same edge
    sifh_pkg::count_t rd_data;

    // histogram side
    modport lane (
        output frame_done,
        output rd_data,
        input release_frame,
        input rd_en,
        input rd_addr
    );

    // readout side
    modport merge (
        input frame_done,
        input rd_data,
        output release_frame,
        output rd_en,
        output rd_addr
    );

endinterface

//--- hw/sifh_pkg.sv
package sifh_pkg;

    // histogram geometry, one memory per lane
    localparam int NUM_BINS = 16;
    localparam int BIN_W = 4;

    // per-lane count, saturating
    localparam int CNT_W = 8;

    // two lane counts added, one bit wider
    localparam int SUM_W = 9;

    // events per lane that close one frame
    localparam int FRAME_EVENTS = 20;

    // bin address
    typedef logic [BIN_W-1:0] bin_t;

    // count held in a lane memory word
    typedef logic [CNT_W-1:0] count_t;

    // merged count on the output stream
    typedef logic [SUM_W-1:0] sum_t;

    // lane FSM
    // clear only runs once after reset
    typedef enum logic [1:0] {
        ACC_RUN,
        ACC_DONE,
        ACC_CLEAR
    } acc_state_t;

    // merge FSM
    typedef enum logic [1:0] {
        MRG_IDLE,
        MRG_READ,
        MRG_SEND,
        MRG_RELEASE
    } mrg_state_t;

endpackage
